// ==== project.f ====
riscv_isa_pkg.sv
rvfi_pkg.sv
pipe_stage.sv
insn_decoder.sv
reg_file.sv
int_execute.sv
rv32i_exec_core.sv
tb_core.sv

// ==== tb_core.sv ====
module tb_core
  import rvfi_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int TIMEOUT = 100;
  localparam logic [6:0] OPC_IMM = 7'h13;

  typedef struct {
    string       name;
    int          phase;
    logic [31:0] pc;
    logic [31:0] insn;
    logic [4:0]  rd;
    logic [31:0] wdata;
    logic [31:0] pc_next;
    logic        trap;
  } vec_t;

  logic         clk = 1'b0;
  logic         reset;
  logic         in_valid;
  logic         in_ready;
  insn_in_t     in_insn;
  logic         out_valid;
  logic         out_ready = 1'b1;
  rvfi_retire_t out_retire;

  vec_t        vecs[$];
  logic [31:0] cur_pc = 32'h0000_0100;
  int          cur_phase;
  int          chk_idx;
  int          value_errors;
  int          other_errors;
  int          seed = 32'h0e1f1337;
  int          rnd;

  rv32i_exec_core #(.ORDER_START(64'd0)) i_dut (
    .clk        (clk),
    .reset      (reset),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .in_insn    (in_insn),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_retire (out_retire)
  );

  always #4 clk = ~clk;

  // Random sink stalls while phase 4 records are due
  always @(posedge clk) begin
    rnd = $random(seed);
    if (!reset && chk_idx < vecs.size() && vecs[chk_idx].phase == 4) begin
      out_ready <= rnd[0];
    end else begin
      out_ready <= 1'b1;
    end
  end

  function automatic logic [31:0] imm_insn(logic [6:0] opc, logic [2:0] f3, int rd, int rs1,
                                           int imm);
    return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
  endfunction

  function automatic logic [31:0] reg_insn(logic [6:0] f7, logic [2:0] f3, int rd, int rs1,
                                           int rs2);
    return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], 7'h33};
  endfunction

  function automatic logic [31:0] br_insn(logic [2:0] f3, int rs1, int rs2, int off);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], 7'h63};
  endfunction

  function automatic logic [31:0] up_insn(logic [6:0] opc, int rd, int imm20);
    return {imm20[19:0], rd[4:0], opc};
  endfunction

  function automatic logic [31:0] jal_insn(int rd, int off);
    return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'h6f};
  endfunction

  task automatic add_entry(string name, logic [31:0] insn, int rd, logic [31:0] wdata,
                           logic [31:0] pc_next, logic trap);
    vec_t v;
    v.name    = name;
    v.phase   = cur_phase;
    v.pc      = cur_pc;
    v.insn    = insn;
    v.rd      = rd[4:0];
    v.wdata   = wdata;
    v.pc_next = pc_next;
    v.trap    = trap;
    vecs.push_back(v);
    cur_pc += 4;
  endtask

  task automatic build_table();
    cur_phase = 1;
    add_entry("addi_pos", imm_insn(OPC_IMM, 3'b000, 1, 0, 5), 1, 32'h5, cur_pc + 4, 1'b0);
    add_entry("addi_neg", imm_insn(OPC_IMM, 3'b000, 2, 1, -12), 2, 32'hffff_fff9, cur_pc + 4, 1'b0);
    add_entry("add", reg_insn(7'h00, 3'b000, 3, 1, 2), 3, 32'hffff_fffe, cur_pc + 4, 1'b0);
    add_entry("sub", reg_insn(7'h20, 3'b000, 4, 1, 2), 4, 32'h0000_000c, cur_pc + 4, 1'b0);
    add_entry("slli", imm_insn(OPC_IMM, 3'b001, 5, 4, 4), 5, 32'h0000_00c0, cur_pc + 4, 1'b0);
    add_entry("srai_neg", imm_insn(OPC_IMM, 3'b101, 6, 2, 'h401), 6, 32'hffff_fffc,
              cur_pc + 4, 1'b0);
    add_entry("srl", reg_insn(7'h00, 3'b101, 7, 3, 1), 7, 32'h07ff_ffff, cur_pc + 4, 1'b0);
    add_entry("slt", reg_insn(7'h00, 3'b010, 8, 2, 1), 8, 32'h1, cur_pc + 4, 1'b0);
    add_entry("sltu", reg_insn(7'h00, 3'b011, 9, 2, 1), 9, 32'h0, cur_pc + 4, 1'b0);
    add_entry("xor", reg_insn(7'h00, 3'b100, 10, 5, 4), 10, 32'h0000_00cc, cur_pc + 4, 1'b0);
    add_entry("or", reg_insn(7'h00, 3'b110, 11, 10, 1), 11, 32'h0000_00cd, cur_pc + 4, 1'b0);
    add_entry("and", reg_insn(7'h00, 3'b111, 12, 11, 4), 12, 32'h0000_000c, cur_pc + 4, 1'b0);

    cur_phase = 2;
    add_entry("lui", up_insn(7'h37, 13, 'h12345), 13, 32'h1234_5000, cur_pc + 4, 1'b0);
    add_entry("auipc", up_insn(7'h17, 14, 1), 14, cur_pc + 32'h1000, cur_pc + 4, 1'b0);
    add_entry("jal_fwd", jal_insn(15, 16), 15, cur_pc + 4, cur_pc + 16, 1'b0);
    add_entry("addi_base", imm_insn(OPC_IMM, 3'b000, 16, 0, 'h203), 16, 32'h203,
              cur_pc + 4, 1'b0);
    // Target 0x209 loses bit 0
    add_entry("jalr_odd", imm_insn(7'h67, 3'b000, 17, 16, 6), 17, cur_pc + 4, 32'h208, 1'b0);
    add_entry("jal_x0", jal_insn(0, -8), 0, 32'h0, cur_pc - 8, 1'b0);

    // x1 = 5, x2 = -7, x4 = 12
    cur_phase = 3;
    add_entry("beq_t", br_insn(3'b000, 1, 1, 8), 0, 32'h0, cur_pc + 8, 1'b0);
    add_entry("beq_n", br_insn(3'b000, 1, 4, 8), 0, 32'h0, cur_pc + 4, 1'b0);
    add_entry("bne_t", br_insn(3'b001, 1, 4, -4), 0, 32'h0, cur_pc - 4, 1'b0);
    add_entry("bne_n", br_insn(3'b001, 1, 1, -4), 0, 32'h0, cur_pc + 4, 1'b0);
    add_entry("blt_t", br_insn(3'b100, 2, 1, 12), 0, 32'h0, cur_pc + 12, 1'b0);
    add_entry("blt_n", br_insn(3'b100, 1, 2, 12), 0, 32'h0, cur_pc + 4, 1'b0);
    add_entry("bge_t", br_insn(3'b101, 1, 2, 16), 0, 32'h0, cur_pc + 16, 1'b0);
    add_entry("bge_n", br_insn(3'b101, 2, 1, 16), 0, 32'h0, cur_pc + 4, 1'b0);
    add_entry("bltu_t", br_insn(3'b110, 1, 2, 20), 0, 32'h0, cur_pc + 20, 1'b0);
    add_entry("bltu_n", br_insn(3'b110, 2, 1, 20), 0, 32'h0, cur_pc + 4, 1'b0);
    add_entry("bgeu_t", br_insn(3'b111, 2, 1, -12), 0, 32'h0, cur_pc - 12, 1'b0);
    add_entry("bgeu_n", br_insn(3'b111, 1, 2, -12), 0, 32'h0, cur_pc + 4, 1'b0);

    cur_phase = 4;
    for (int k = 1; k <= 10; k++) begin
      add_entry($sformatf("bp_addi_%0d", k), imm_insn(OPC_IMM, 3'b000, 18, 18, 3), 18, 3 * k,
                cur_pc + 4, 1'b0);
    end

    cur_phase = 5;
    add_entry("ecall", 32'h0000_0073, 0, 32'h0, cur_pc + 4, 1'b1);
    add_entry("ebreak", 32'h0010_0073, 0, 32'h0, cur_pc + 4, 1'b1);
    add_entry("sll_alt_x1", reg_insn(7'h20, 3'b001, 1, 1, 1), 0, 32'h0, cur_pc + 4, 1'b1);
    add_entry("all_ones", 32'hffff_ffff, 0, 32'h0, cur_pc + 4, 1'b1);
    add_entry("addi_x0", imm_insn(OPC_IMM, 3'b000, 0, 1, 100), 0, 32'h0, cur_pc + 4, 1'b0);
    add_entry("read_x0_x1", reg_insn(7'h00, 3'b000, 19, 0, 1), 19, 32'h5, cur_pc + 4, 1'b0);
    add_entry("read_x31", reg_insn(7'h00, 3'b000, 20, 31, 0), 20, 32'h0, cur_pc + 4, 1'b0);
    add_entry("fence", 32'h0ff0_000f, 0, 32'h0, cur_pc + 4, 1'b0);
  endtask

  task automatic check_field(string test, string field, logic [63:0] exp, logic [63:0] got);
    assert (got == exp) else begin
      $display("FAIL %s %s: expected %0h, actual %0h", test, field, exp, got);
      value_errors++;
    end
  endtask

  task automatic drive_stream();
    int   waited;
    logic taken;
    foreach (vecs[i]) begin
      in_valid     <= 1'b1;
      in_insn.pc   <= vecs[i].pc;
      in_insn.insn <= vecs[i].insn;
      waited = 0;
      taken  = 1'b0;
      while (!taken && waited < TIMEOUT) begin
        @(negedge clk);
        taken = in_ready;
        @(posedge clk);
        waited++;
      end
      if (!taken) begin
        $display("Timed out waiting for the core to accept %s", vecs[i].name);
        other_errors++;
        in_valid <= 1'b0;
        return;
      end
    end
    in_valid <= 1'b0;
  endtask

  task automatic check_stream();
    int           waited;
    rvfi_retire_t rec;
    logic [31:0]  model [32];
    logic [6:0]   opc;
    logic [4:0]   src1;
    logic [4:0]   src2;
    // Registers start at zero after reset
    foreach (model[r]) begin
      model[r] = '0;
    end
    foreach (vecs[i]) begin
      waited = 0;
      do begin
        @(negedge clk);
        waited++;
      end while (!(out_valid && out_ready) && waited < TIMEOUT);
      if (!(out_valid && out_ready)) begin
        $display("Timed out waiting for the retirement record of %s", vecs[i].name);
        other_errors++;
        return;
      end
      rec = out_retire;
      // Only JALR, OP_IMM, branches and OP read sources, and a trap reads none
      opc  = vecs[i].insn[6:0];
      src1 = 5'd0;
      src2 = 5'd0;
      if (!vecs[i].trap && opc inside {7'h67, 7'h63, 7'h13, 7'h33}) begin
        src1 = vecs[i].insn[19:15];
      end
      if (!vecs[i].trap && opc inside {7'h63, 7'h33}) begin
        src2 = vecs[i].insn[24:20];
      end
      check_field(vecs[i].name, "order", i, rec.order);
      check_field(vecs[i].name, "insn", vecs[i].insn, rec.insn);
      check_field(vecs[i].name, "pc_rdata", vecs[i].pc, rec.pc_rdata);
      check_field(vecs[i].name, "rs1_addr", src1, rec.rs1_addr);
      check_field(vecs[i].name, "rs2_addr", src2, rec.rs2_addr);
      check_field(vecs[i].name, "rs1_rdata", model[src1], rec.rs1_rdata);
      check_field(vecs[i].name, "rs2_rdata", model[src2], rec.rs2_rdata);
      check_field(vecs[i].name, "rd_addr", vecs[i].rd, rec.rd_addr);
      check_field(vecs[i].name, "rd_wdata", vecs[i].wdata, rec.rd_wdata);
      check_field(vecs[i].name, "pc_wdata", vecs[i].pc_next, rec.pc_wdata);
      check_field(vecs[i].name, "trap", vecs[i].trap, rec.trap);
      // Shadow registers follow the table's expected writeback
      if (vecs[i].rd != '0) begin
        model[vecs[i].rd] = vecs[i].wdata;
      end
      chk_idx = i + 1;
    end
  endtask

  initial begin
    reset    = 1'b1;
    in_valid = 1'b0;
    in_insn  = '0;
    build_table();
    repeat (4) @(posedge clk);
    reset <= 1'b0;
    fork
      drive_stream();
      check_stream();
    join
    // Nothing may retire beyond the table
    repeat (10) begin
      @(negedge clk);
      assert (!out_valid) else begin
        $display("The core produced a retirement record beyond the end of the table");
        other_errors++;
      end
    end
    $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// ==== rv32i_exec_core.sv ====
module rv32i_exec_core
  import riscv_isa_pkg::*;
  import rvfi_pkg::*;
#(
  parameter logic [63:0] ORDER_START = 64'd0
) (
  input  logic         clk,
  input  logic         reset,
  input  logic         in_valid,
  output logic         in_ready,
  input  insn_in_t     in_insn,
  output logic         out_valid,
  input  logic         out_ready,
  output rvfi_retire_t out_retire
);

  decoded_insn_t dec_in;
  decoded_insn_t dec_q;
  logic          dec_valid;
  logic          ret_ready;
  logic          ret_accept;
  xlen_t         rs1_data;
  xlen_t         rs2_data;
  xlen_t         rd_wdata;
  xlen_t         pc_wdata;
  logic          rd_write;
  logic          trap;
  logic          uses_rs1;
  logic          uses_rs2;
  logic          rf_we;
  logic [63:0]   order_q;
  rvfi_retire_t  retire;

  insn_decoder u_decoder (
    .insn    (in_insn),
    .decoded (dec_in)
  );

  pipe_stage #(.payload_t(decoded_insn_t)) u_dec_stage (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_data   (dec_in),
    .out_valid (dec_valid),
    .out_ready (ret_ready),
    .out_data  (dec_q)
  );

  reg_file u_reg_file (
    .clk      (clk),
    .reset    (reset),
    .rs1_addr (dec_q.rs1),
    .rs2_addr (dec_q.rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wr_en    (rf_we),
    .wr_addr  (dec_q.rd),
    .wr_data  (rd_wdata)
  );

  int_execute u_execute (
    .decoded  (dec_q),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .rd_wdata (rd_wdata),
    .rd_write (rd_write),
    .pc_wdata (pc_wdata),
    .trap     (trap)
  );

  // Writeback and order advance only when the record is taken
  assign ret_accept = dec_valid && ret_ready;
  assign rf_we      = ret_accept && rd_write && (dec_q.rd != '0);

  assign uses_rs1 = dec_q.insn_class inside {CLS_JALR, CLS_BRANCH, CLS_OP_IMM, CLS_OP};
  assign uses_rs2 = dec_q.insn_class inside {CLS_BRANCH, CLS_OP};

  always_ff @(posedge clk) begin
    if (reset) begin
      order_q <= ORDER_START;
    end else if (ret_accept) begin
      order_q <= order_q + 64'd1;
    end
  end

  always_comb begin
    retire.order     = order_q;
    retire.insn      = dec_q.insn;
    retire.trap      = trap;
    retire.rs1_addr  = uses_rs1 ? dec_q.rs1 : '0;
    retire.rs2_addr  = uses_rs2 ? dec_q.rs2 : '0;
    retire.rs1_rdata = uses_rs1 ? rs1_data : '0;
    retire.rs2_rdata = uses_rs2 ? rs2_data : '0;
    // No write reports rd as x0 with zero data
    retire.rd_addr   = rd_write ? dec_q.rd : '0;
    retire.rd_wdata  = (rd_write && dec_q.rd != '0) ? rd_wdata : '0;
    retire.pc_rdata  = dec_q.pc;
    retire.pc_wdata  = pc_wdata;
  end

  pipe_stage #(.payload_t(rvfi_retire_t)) u_ret_stage (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (dec_valid),
    .in_ready  (ret_ready),
    .in_data   (retire),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_retire)
  );

endmodule

// ==== int_execute.sv ====
module int_execute
  import riscv_isa_pkg::*;
(
  input  decoded_insn_t decoded,
  input  xlen_t         rs1_data,
  input  xlen_t         rs2_data,
  output xlen_t         rd_wdata,
  output logic          rd_write,
  output xlen_t         pc_wdata,
  output logic          trap
);

  xlen_t op_b;
  xlen_t alu_res;
  xlen_t pc_plus4;
  xlen_t pc_plus_imm;
  xlen_t jalr_target;
  logic  br_taken;

  assign op_b        = decoded.use_imm ? decoded.imm : rs2_data;
  assign pc_plus4    = decoded.pc + 32'd4;
  assign pc_plus_imm = decoded.pc + decoded.imm;
  assign jalr_target = (rs1_data + decoded.imm) & ~32'd1;

  always_comb begin
    unique case (decoded.alu_op)
      ALU_ADD:  alu_res = rs1_data + op_b;
      ALU_SUB:  alu_res = rs1_data - op_b;
      ALU_SLL:  alu_res = rs1_data << op_b[4:0];
      ALU_SLT:  alu_res = {31'b0, $signed(rs1_data) < $signed(op_b)};
      ALU_SLTU: alu_res = {31'b0, rs1_data < op_b};
      ALU_XOR:  alu_res = rs1_data ^ op_b;
      ALU_SRL:  alu_res = rs1_data >> op_b[4:0];
      ALU_SRA:  alu_res = xlen_t'($signed(rs1_data) >>> op_b[4:0]);
      ALU_OR:   alu_res = rs1_data | op_b;
      ALU_AND:  alu_res = rs1_data & op_b;
      default:  alu_res = '0;
    endcase
  end

  always_comb begin
    unique case (decoded.br_funct3)
      F3_BEQ:  br_taken = rs1_data == rs2_data;
      F3_BNE:  br_taken = rs1_data != rs2_data;
      F3_BLT:  br_taken = $signed(rs1_data) < $signed(rs2_data);
      F3_BGE:  br_taken = $signed(rs1_data) >= $signed(rs2_data);
      F3_BLTU: br_taken = rs1_data < rs2_data;
      F3_BGEU: br_taken = rs1_data >= rs2_data;
      default: br_taken = 1'b0;
    endcase
  end

  // Result and next PC per class
  always_comb begin
    rd_wdata = alu_res;
    rd_write = 1'b1;
    pc_wdata = pc_plus4;
    trap     = 1'b0;
    unique case (decoded.insn_class)
      CLS_LUI:   rd_wdata = decoded.imm;
      CLS_AUIPC: rd_wdata = pc_plus_imm;
      CLS_JAL: begin
        rd_wdata = pc_plus4;
        pc_wdata = pc_plus_imm;
      end
      CLS_JALR: begin
        rd_wdata = pc_plus4;
        pc_wdata = jalr_target;
      end
      CLS_BRANCH: begin
        rd_wdata = '0;
        rd_write = 1'b0;
        if (br_taken) pc_wdata = pc_plus_imm;
      end
      CLS_OP_IMM, CLS_OP: rd_wdata = alu_res;
      CLS_FENCE: begin
        rd_wdata = '0;
        rd_write = 1'b0;
      end
      default: begin
        rd_wdata = '0;
        rd_write = 1'b0;
        trap     = 1'b1;
      end
    endcase
  end

endmodule

// ==== reg_file.sv ====
module reg_file
  import riscv_isa_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  reg_addr_t rs1_addr,
  input  reg_addr_t rs2_addr,
  output xlen_t     rs1_data,
  output xlen_t     rs2_data,
  input  logic      wr_en,
  input  reg_addr_t wr_addr,
  input  xlen_t     wr_data
);

  // x0 has no storage
  xlen_t regs [1:31];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int n = 1; n < 32; n++) begin
        regs[n] <= '0;
      end
    end else if (wr_en && wr_addr != '0) begin
      regs[wr_addr] <= wr_data;
    end
  end

  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

// ==== insn_decoder.sv ====
module insn_decoder
  import riscv_isa_pkg::*;
  import rvfi_pkg::*;
(
  input  insn_in_t      insn,
  output decoded_insn_t decoded
);

  r_type_t r;
  i_type_t i;
  b_type_t b;
  u_type_t u;
  j_type_t j;
  xlen_t   imm_i;
  xlen_t   imm_b;
  xlen_t   imm_u;
  xlen_t   imm_j;

  assign r = insn.insn;
  assign i = insn.insn;
  assign b = insn.insn;
  assign u = insn.insn;
  assign j = insn.insn;

  assign imm_i = {{20{i.imm_11_0[11]}}, i.imm_11_0};
  assign imm_b = {{19{b.imm_12}}, b.imm_12, b.imm_11, b.imm_10_5, b.imm_4_1, 1'b0};
  assign imm_u = {u.imm_31_12, 12'b0};
  assign imm_j = {{11{j.imm_20}}, j.imm_20, j.imm_19_12, j.imm_11, j.imm_10_1, 1'b0};

  // alt selects SUB or SRA
  function automatic alu_op_e alu_sel(logic [2:0] funct3, logic alt);
    alu_op_e op;
    unique case (funct3)
      F3_ADD:  op = alt ? ALU_SUB : ALU_ADD;
      F3_SLL:  op = ALU_SLL;
      F3_SLT:  op = ALU_SLT;
      F3_SLTU: op = ALU_SLTU;
      F3_XOR:  op = ALU_XOR;
      F3_SR:   op = alt ? ALU_SRA : ALU_SRL;
      F3_OR:   op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  always_comb begin
    decoded            = '0;
    decoded.pc         = insn.pc;
    decoded.insn       = insn.insn;
    decoded.rs1        = r.rs1;
    decoded.rs2        = r.rs2;
    decoded.rd         = r.rd;
    decoded.br_funct3  = r.funct3;
    decoded.insn_class = CLS_TRAP;
    decoded.alu_op     = ALU_ADD;
    decoded.imm        = imm_i;
    decoded.use_imm    = 1'b1;

    unique case (r.opcode)
      OPC_LUI: begin
        decoded.insn_class = CLS_LUI;
        decoded.imm        = imm_u;
      end
      OPC_AUIPC: begin
        decoded.insn_class = CLS_AUIPC;
        decoded.imm        = imm_u;
      end
      OPC_JAL: begin
        decoded.insn_class = CLS_JAL;
        decoded.imm        = imm_j;
      end
      OPC_JALR: begin
        if (r.funct3 == 3'b000) decoded.insn_class = CLS_JALR;
      end
      OPC_BRANCH: begin
        decoded.imm     = imm_b;
        decoded.use_imm = 1'b0;
        if (r.funct3 != 3'b010 && r.funct3 != 3'b011) decoded.insn_class = CLS_BRANCH;
      end
      OPC_OP_IMM: begin
        // Only the shifts carry funct7 bits in the immediate
        decoded.alu_op = alu_sel(r.funct3, (r.funct3 == F3_SR) && r.funct7[5]);
        if (r.funct3 == F3_SLL) begin
          if (r.funct7 == F7_BASE) decoded.insn_class = CLS_OP_IMM;
        end else if (r.funct3 == F3_SR) begin
          if (r.funct7 == F7_BASE || r.funct7 == F7_ALT) decoded.insn_class = CLS_OP_IMM;
        end else begin
          decoded.insn_class = CLS_OP_IMM;
        end
      end
      OPC_OP: begin
        decoded.use_imm = 1'b0;
        decoded.alu_op  = alu_sel(r.funct3, r.funct7[5]);
        if (r.funct7 == F7_BASE ||
            (r.funct7 == F7_ALT && (r.funct3 == F3_ADD || r.funct3 == F3_SR))) begin
          decoded.insn_class = CLS_OP;
        end
      end
      OPC_FENCE: begin
        if (r.funct3 == 3'b000) decoded.insn_class = CLS_FENCE;
      end
      // ECALL, EBREAK and all of SYSTEM stay TRAP
      default: decoded.insn_class = CLS_TRAP;
    endcase
  end

endmodule

// ==== pipe_stage.sv ====
module pipe_stage #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_data,
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_data
);

  logic     full;
  payload_t data_q;

  // Open when empty or when the held item leaves this cycle
  assign in_ready  = !full || out_ready;
  assign out_valid = full;
  assign out_data  = data_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      full <= 1'b0;
    end else if (in_ready) begin
      full <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      data_q <= in_data;
    end
  end

endmodule

// ==== rvfi_pkg.sv ====
package rvfi_pkg;

  import riscv_isa_pkg::*;

  // Instruction word as delivered by the stream
  typedef struct packed {
    xlen_t       pc;
    logic [31:0] insn;
  } insn_in_t;

  // One retirement record, RVFI field naming
  typedef struct packed {
    logic [63:0] order;
    logic [31:0] insn;
    logic        trap;
    reg_addr_t   rs1_addr;
    reg_addr_t   rs2_addr;
    xlen_t       rs1_rdata;
    xlen_t       rs2_rdata;
    reg_addr_t   rd_addr;
    xlen_t       rd_wdata;
    xlen_t       pc_rdata;
    xlen_t       pc_wdata;
  } rvfi_retire_t;

endpackage

// ==== riscv_isa_pkg.sv ====
package riscv_isa_pkg;

  typedef logic [31:0] xlen_t;
  typedef logic [4:0]  reg_addr_t;

  // Major opcodes
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_FENCE  = 7'b0001111;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  // ALU funct3
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101;
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  // Branch funct3
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
  } alu_op_e;

  typedef enum logic [3:0] {
    CLS_LUI, CLS_AUIPC, CLS_JAL, CLS_JALR, CLS_BRANCH,
    CLS_OP_IMM, CLS_OP, CLS_FENCE, CLS_TRAP
  } insn_class_e;

  typedef struct packed {
    logic [6:0] funct7;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    reg_addr_t  rd;
    logic [6:0] opcode;
  } r_type_t;

  typedef struct packed {
    logic [11:0] imm_11_0;
    reg_addr_t   rs1;
    logic [2:0]  funct3;
    reg_addr_t   rd;
    logic [6:0]  opcode;
  } i_type_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    logic [6:0] opcode;
  } s_type_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_type_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    reg_addr_t   rd;
    logic [6:0]  opcode;
  } u_type_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    reg_addr_t  rd;
    logic [6:0] opcode;
  } j_type_t;

  typedef struct packed {
    xlen_t       pc;
    logic [31:0] insn;
    insn_class_e insn_class;
    alu_op_e     alu_op;
    logic [2:0]  br_funct3;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    reg_addr_t   rd;
    xlen_t       imm;
    logic        use_imm;
  } decoded_insn_t;

endpackage
